//--- hw/polar_pkg.sv
// ----------------------------------------------------------
// Polar SIMD ALU shared definitions
// Lane and word types, clip limits, opcodes and pipe records
// ----------------------------------------------------------

`default_nettype none

package polar_pkg;

  // Lane geometry
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = 4;
  localparam int WORD_W    = LANE_W * NUM_LANES;

  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [LANE_W:0]   lane_sum_t;
  typedef logic [WORD_W-1:0] word_t;

  // Symmetric clip range for LLR arithmetic
  localparam lane_t SAT_MAX     = 8'h7F;
  localparam lane_t SAT_MIN     = 8'h81;
  localparam lane_t FROZEN_MARK = 8'h01;

  // Codes 6 and 7 are reserved
  typedef enum logic [2:0] {
    PL_F      = 3'd0,
    PL_ADDSAT = 3'd1,
    PL_SUBSAT = 3'd2,
    PL_DECODE = 3'd3,
    PL_R      = 3'd4,
    PL_EVAL   = 3'd5
  } polar_op_e;

  typedef struct packed {
    polar_op_e op;
    word_t     operand_a;
    word_t     operand_b;
  } polar_req_t;

  // Precomputed terms for one lane
  typedef struct packed {
    lane_t     mag_a;
    lane_t     mag_b;
    logic      sign_x;
    lane_sum_t sum;
    lane_sum_t diff;
  } lane_pre_t;

  typedef struct packed {
    polar_op_e                  op;
    word_t                      operand_a;
    word_t                      operand_b;
    lane_pre_t [NUM_LANES-1:0]  lanes;
  } polar_rec_t;

endpackage

`default_nettype wire

//--- hw/polar_operand_stage.sv
// ----------------------------------------------------------
// Polar ALU operand stage
// Registers requests with per-lane signs, magnitudes and sums
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module polar_operand_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  polar_pkg::polar_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output polar_pkg::polar_rec_t  rec_o,
  output logic                   rec_valid_o,
  input  logic                   rec_ready_i
);

  localparam int MSB = polar_pkg::LANE_W - 1;

  polar_pkg::polar_rec_t rec_d;
  logic                  req_fire;

  // Register is free when empty or being drained this cycle
  assign req_ready_o = ~rec_valid_o | rec_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  // ------------------------------------------------------------
  // Per-lane precompute
  // ------------------------------------------------------------
  always_comb begin
    polar_pkg::lane_t a_l;
    polar_pkg::lane_t b_l;

    rec_d.op        = req_i.op;
    rec_d.operand_a = req_i.operand_a;
    rec_d.operand_b = req_i.operand_b;

    for (int l = 0; l < polar_pkg::NUM_LANES; l++) begin
      a_l = req_i.operand_a[l*polar_pkg::LANE_W +: polar_pkg::LANE_W];
      b_l = req_i.operand_b[l*polar_pkg::LANE_W +: polar_pkg::LANE_W];

      // Two's-complement negation, so -128 keeps magnitude 0x80
      rec_d.lanes[l].mag_a  = a_l[MSB] ? -a_l : a_l;
      rec_d.lanes[l].mag_b  = b_l[MSB] ? -b_l : b_l;
      rec_d.lanes[l].sign_x = a_l[MSB] ^ b_l[MSB];

      // Sign-extended to 9 bits so nothing wraps
      rec_d.lanes[l].sum  = polar_pkg::lane_sum_t'({a_l[MSB], a_l})
                          + polar_pkg::lane_sum_t'({b_l[MSB], b_l});
      rec_d.lanes[l].diff = polar_pkg::lane_sum_t'({a_l[MSB], a_l})
                          - polar_pkg::lane_sum_t'({b_l[MSB], b_l});
    end
  end

  // ------------------------------------------------------------
  // Pipeline register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rec_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      rec_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rec_o <= rec_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/polar_fifo.sv
// ----------------------------------------------------------
// Polar ALU record FIFO
// Circular buffer between operand and result stages
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module polar_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  polar_pkg::polar_rec_t  push_i,
  input  logic                   push_valid_i,
  output logic                   push_ready_o,
  output polar_pkg::polar_rec_t  pop_o,
  output logic                   pop_valid_o,
  input  logic                   pop_ready_i
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  polar_pkg::polar_rec_t mem [DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;
  logic push_fire;
  logic pop_fire;

  // Full blocks pushes even when a pop happens in the same cycle
  assign push_ready_o = (count != cnt_t'(DEPTH));
  assign pop_valid_o  = (count != '0);
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_ready_i & pop_valid_o;

  assign pop_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_i;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Explicit wrap so non power-of-two depths work
      if (push_fire) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/polar_result_stage.sv
// ----------------------------------------------------------
// Polar ALU result stage
// Selects the lane results per opcode into the output register
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module polar_result_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  polar_pkg::polar_rec_t  rec_i,
  input  logic                   rec_valid_i,
  output logic                   rec_ready_o,
  output polar_pkg::word_t       result_o,
  output logic                   result_valid_o,
  input  logic                   result_ready_i
);

  localparam int MSB = polar_pkg::LANE_W - 1;

  polar_pkg::word_t result_d;
  logic             rec_fire;

  // Clip a 9-bit signed value to the symmetric LLR range
  function automatic polar_pkg::lane_t sat_lane(input polar_pkg::lane_sum_t v);
    polar_pkg::lane_t res;
    if ($signed(v) > $signed({1'b0, polar_pkg::SAT_MAX})) begin
      res = polar_pkg::SAT_MAX;
    end else if ($signed(v) < $signed({1'b1, polar_pkg::SAT_MIN})) begin
      res = polar_pkg::SAT_MIN;
    end else begin
      res = v[MSB:0];
    end
    return res;
  endfunction

  assign rec_ready_o = ~result_valid_o | result_ready_i;
  assign rec_fire    = rec_valid_i & rec_ready_o;

  // ------------------------------------------------------------
  // Per-lane result select
  // ------------------------------------------------------------
  always_comb begin
    polar_pkg::lane_t     a_l;
    polar_pkg::lane_t     b_low;
    polar_pkg::lane_t     min_mag;
    polar_pkg::lane_t     lane_res;
    polar_pkg::lane_pre_t pre;

    b_low    = rec_i.operand_b[MSB:0];
    result_d = '0;

    for (int l = 0; l < polar_pkg::NUM_LANES; l++) begin
      a_l     = rec_i.operand_a[l*polar_pkg::LANE_W +: polar_pkg::LANE_W];
      pre     = rec_i.lanes[l];
      min_mag = (pre.mag_a > pre.mag_b) ? pre.mag_b : pre.mag_a;

      case (rec_i.op)
        // Min-sum check node
        polar_pkg::PL_F:      lane_res = pre.sign_x ? -min_mag : min_mag;
        polar_pkg::PL_ADDSAT: lane_res = sat_lane(pre.sum);
        polar_pkg::PL_SUBSAT: lane_res = sat_lane(pre.diff);
        polar_pkg::PL_DECODE: lane_res = (b_low == '0) ? a_l : '0;
        // Hard decision, suppressed on frozen bits
        polar_pkg::PL_R: begin
          lane_res = (b_low == polar_pkg::FROZEN_MARK) ? '0
                   : polar_pkg::lane_t'(a_l[MSB]);
        end
        polar_pkg::PL_EVAL:   lane_res = (a_l == polar_pkg::lane_t'(1)) ? '1 : '0;
        default:              lane_res = '0;
      endcase

      result_d[l*polar_pkg::LANE_W +: polar_pkg::LANE_W] = lane_res;
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
    end else if (rec_ready_o) begin
      result_valid_o <= rec_valid_i;
    end
  end

  // Held while the sink stalls
  always_ff @(posedge clk_i) begin
    if (rec_fire) begin
      result_o <= result_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/polar_alu_top.sv
// ----------------------------------------------------------
// Polar SIMD ALU top level
// Operand stage, record FIFO and result stage in a pipeline
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module polar_alu_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  polar_pkg::polar_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output polar_pkg::word_t       result_o,
  output logic                   result_valid_o,
  input  logic                   result_ready_i
);

  // Operand stage to FIFO
  polar_pkg::polar_rec_t stage_rec;
  logic                  stage_valid;
  logic                  stage_ready;

  // FIFO to result stage
  polar_pkg::polar_rec_t fifo_rec;
  logic                  fifo_valid;
  logic                  fifo_ready;

  polar_operand_stage u_operand_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rec_o       (stage_rec),
    .rec_valid_o (stage_valid),
    .rec_ready_i (stage_ready)
  );

  polar_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (stage_rec),
    .push_valid_i (stage_valid),
    .push_ready_o (stage_ready),
    .pop_o        (fifo_rec),
    .pop_valid_o  (fifo_valid),
    .pop_ready_i  (fifo_ready)
  );

  polar_result_stage u_result_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rec_i          (fifo_rec),
    .rec_valid_i    (fifo_valid),
    .rec_ready_o    (fifo_ready),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

//--- test/polar_alu_props.sv
// ----------------------------------------------------------
// Polar SIMD ALU handshake properties
// Bound to the top level, reset and valid/ready rules
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module polar_alu_props #(
  parameter int FIFO_DEPTH = 4
) (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             req_valid_i,
  input logic             req_ready_i,
  input polar_pkg::word_t result_i,
  input logic             result_valid_i,
  input logic             result_ready_i
);

  // Items accepted at the input and not yet delivered
  int   in_flight;
  logic in_fire;
  logic out_fire;

  assign in_fire  = req_valid_i & req_ready_i;
  assign out_fire = result_valid_i & result_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_flight <= 0;
    end else begin
      case ({in_fire, out_fire})
        2'b10:   in_flight <= in_flight + 1;
        2'b01:   in_flight <= in_flight - 1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Output register comes up empty
  reset_clears_valid: assert property (@(posedge clk_i) !rst_n_i |=> !result_valid_i)
    else $error("result_valid_o high in the cycle after reset");

  // Result held while the sink stalls
  result_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (result_valid_i && !result_ready_i) |=> (result_valid_i && $stable(result_i)))
    else $error("result_o or result_valid_o changed under back-pressure");

  // With no more items than FIFO slots the FIFO can never block the producer
  req_ready_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (in_flight <= FIFO_DEPTH) |-> req_ready_i)
    else $error("req_ready_o low with room in the FIFO");

endmodule

bind polar_alu_top polar_alu_props #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_props (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_valid_i    (req_valid_i),
  .req_ready_i    (req_ready_o),
  .result_i       (result_o),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i)
);

`default_nettype wire

//--- test/polar_alu_tb.sv
// ----------------------------------------------------------
// Polar SIMD ALU testbench
// Table-driven requests, random output stalls, in-order checks
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module polar_alu_tb;

  localparam int FIFO_DEPTH     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int REQ_TIMEOUT    = 100;
  localparam int RESULT_TIMEOUT = 100;
  localparam int DRAIN_CYCLES   = 8;
  // Output held off long enough to back up the whole pipe
  localparam int STALL_FIRST    = 4;
  localparam int STALL_LAST     = 35;
  localparam logic [31:0] SEED  = 32'hc74e38d3;

  typedef struct packed {
    polar_pkg::polar_req_t req;
    polar_pkg::word_t      expected;
  } vector_t;

  logic                  clk;
  logic                  rst_n;
  polar_pkg::polar_req_t req;
  logic                  req_valid;
  logic                  req_ready;
  polar_pkg::word_t      result;
  logic                  result_valid;
  logic                  result_ready;

  vector_t vectors[$];
  logic    stall_seen;

  polar_alu_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .result_o       (result),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready)
  );

  always #2 clk = ~clk;

  task automatic add_vec(input logic [2:0] op_code, input polar_pkg::word_t a,
                         input polar_pkg::word_t b, input polar_pkg::word_t exp);
    vector_t v;
    v.req.op        = polar_pkg::polar_op_e'(op_code);
    v.req.operand_a = a;
    v.req.operand_b = b;
    v.expected      = exp;
    vectors.push_back(v);
  endtask

  // ----------------------------------------------------------
  // Stimulus table, lane 0 is the low byte
  // ----------------------------------------------------------
  task automatic load_vectors();
    // Min-sum: equal mags, -128 lanes, zero against -128
    add_vec(polar_pkg::PL_F,      32'h05FB8010, 32'h030305F0, 32'h03FDFBF0);
    add_vec(polar_pkg::PL_F,      32'h80807FE0, 32'h800181E8, 32'h80FF8118);
    add_vec(polar_pkg::PL_F,      32'h00808001, 32'h057F90FF, 32'h008170FF);
    add_vec(polar_pkg::PL_F,      32'h00000000, 32'h80808080, 32'h00000000);
    add_vec(polar_pkg::PL_ADDSAT, 32'h107F8005, 32'h2001FF03, 32'h307F8108);
    add_vec(polar_pkg::PL_ADDSAT, 32'h81C0F664, 32'h00C00A1C, 32'h8181007F);
    add_vec(polar_pkg::PL_ADDSAT, 32'h7F7F7F7F, 32'h7F7F7F7F, 32'h7F7F7F7F);
    add_vec(polar_pkg::PL_SUBSAT, 32'h807F0A05, 32'h01FF1403, 32'h817FF602);
    add_vec(polar_pkg::PL_SUBSAT, 32'h0080C840, 32'h7F8038C0, 32'h8100907F);
    add_vec(polar_pkg::PL_SUBSAT, 32'h80808080, 32'h7F7F7F7F, 32'h81818181);
    add_vec(polar_pkg::PL_DECODE, 32'hDEADBEEF, 32'h12345600, 32'hDEADBEEF);
    add_vec(polar_pkg::PL_DECODE, 32'hDEADBEEF, 32'h00000001, 32'h00000000);
    add_vec(polar_pkg::PL_DECODE, 32'h807F01FF, 32'hFFFFFF00, 32'h807F01FF);
    // Hard decision, low byte 1 freezes the bit
    add_vec(polar_pkg::PL_R,      32'h8001FF7F, 32'h00000000, 32'h01000100);
    add_vec(polar_pkg::PL_R,      32'h8001FF7F, 32'h00000001, 32'h00000000);
    add_vec(polar_pkg::PL_R,      32'h8001FF7F, 32'h00000102, 32'h01000100);
    add_vec(polar_pkg::PL_R,      32'h8001FF7F, 32'hFFFFFF01, 32'h00000000);
    add_vec(polar_pkg::PL_EVAL,   32'h010001FF, 32'hFFFFFFFF, 32'hFF00FF00);
    add_vec(polar_pkg::PL_EVAL,   32'h01010101, 32'h00000000, 32'hFFFFFFFF);
    add_vec(polar_pkg::PL_EVAL,   32'h10810200, 32'h00000001, 32'h00000000);
    add_vec(3'd6,                 32'h12345678, 32'h00000000, 32'h00000000);
    add_vec(3'd7,                 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000000);
  endtask

  task automatic drive_requests();
    int waited;
    @(negedge clk);
    for (int i = 0; i < vectors.size(); i++) begin
      req       = vectors[i].req;
      req_valid = 1'b1;
      waited    = 0;
      #1;
      while (!req_ready) begin
        stall_seen = 1'b1;
        waited++;
        assert (waited < REQ_TIMEOUT) else begin
          $display("Timed out waiting for req_ready_o on entry %0d", i);
          $display("TEST FAIL");
          $fatal(1, "request stuck");
        end
        @(negedge clk);
        #1;
      end
      @(negedge clk);
    end
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic collect_results();
    int idx;
    int idle;
    int cycle;
    idx   = 0;
    idle  = 0;
    cycle = 0;
    while (idx < vectors.size()) begin
      @(negedge clk);
      if (cycle >= STALL_FIRST && cycle <= STALL_LAST) begin
        result_ready = 1'b0;
      end else begin
        result_ready = (($urandom() & 32'h3) != 32'h0);
      end
      cycle++;
      #1;
      if (result_valid && result_ready) begin
        assert (result == vectors[idx].expected) else begin
          $display("Error at %0t: result_o = %h, expected %h (entry %0d)",
                   $time, result, vectors[idx].expected, idx);
          $display("TEST FAIL");
          $fatal(1, "result mismatch");
        end
        idx++;
        idle = 0;
      end else begin
        idle++;
        assert (idle < RESULT_TIMEOUT) else begin
          $display("Timed out waiting for result %0d on result_valid_o", idx);
          $display("TEST FAIL");
          $fatal(1, "result missing");
        end
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    result_ready = 1'b0;
    stall_seen   = 1'b0;
    void'($urandom(SEED));
    load_vectors();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (!result_valid && req_ready) else begin
      $display("Error at %0t: result_valid_o = %b (expected 0), req_ready_o = %b (expected 1)",
               $time, result_valid, req_ready);
      $display("TEST FAIL");
      $fatal(1, "bad reset state");
    end

    fork
      drive_requests();
      collect_results();
    join

    // Nothing may follow the last expected result
    @(negedge clk);
    result_ready = 1'b1;
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      #1;
      assert (!result_valid) else begin
        $display("Error at %0t: result_valid_o = %b after the last result, expected 0",
                 $time, result_valid);
        $display("TEST FAIL");
        $fatal(1, "extra result");
      end
      @(negedge clk);
    end

    assert (stall_seen) else begin
      $display("req_ready_o never went low while the output was stalled");
      $display("TEST FAIL");
      $fatal(1, "no back-pressure seen");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/polar_pkg.sv
hw/polar_operand_stage.sv
hw/polar_fifo.sv
hw/polar_result_stage.sv
hw/polar_alu_top.sv
test/polar_alu_props.sv
test/polar_alu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the polar ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module polar_alu_tb \
  -f sources.f \
  -o polar_alu_sim

./obj_dir/polar_alu_sim
